// File: all.f
+incdir+logic
logic/fetch_pkg.sv
logic/mem_bus_pkg.sv
logic/fetch_front.sv
logic/cache_store.sv
logic/miss_queue.sv
logic/mem_bus_port.sv
logic/icache_top.sv
verif/tb_memory.sv
verif/icache_tb.sv

// File: logic/cache_store.sv
`default_nettype none
`timescale 1ns/100ps
`include "icache_defines.svh"

module cache_store (
  input  wire                                 clock,
  input  wire                                 reset,
  input  wire  fetch_pkg::fetch_addr_t [1:0]  rd_addr,
  input  wire  fetch_pkg::cache_fill_t        fill,
  output fetch_pkg::line_data_t [1:0]         rd_data,
  output logic [1:0]                          rd_hit
);
  import fetch_pkg::*;

  localparam int WAYS     = `ICACHE_WAYS;
  localparam int SETS     = `ICACHE_SETS;
  localparam int SET_BITS = $clog2(SETS);
  localparam int WAY_BITS = $clog2(WAYS);

  logic [WAYS-1:0]     valid_mem [SETS];
  line_tag_t           tag_mem   [SETS][WAYS];
  line_data_t          data_mem  [SETS][WAYS];
  logic [WAY_BITS-1:0] rr_ptr    [SETS];

  set_idx_t            fill_idx;
  line_tag_t           fill_tag;
  logic [WAYS-1:0]     fill_match;
  logic [WAY_BITS-1:0] fill_way;
  logic                dup_tag;

  ////////////////////
  // read ports

  // all ways compared in parallel
  always_comb begin
    set_idx_t  idx;
    line_tag_t tag;
    for (int p = 0; p < 2; p++) begin
      idx        = rd_addr[p][3 +: SET_BITS];
      tag        = rd_addr[p][31:3+SET_BITS];
      rd_hit[p]  = 1'b0;
      rd_data[p] = '0;
      for (int w = 0; w < WAYS; w++) begin
        if (valid_mem[idx][w] && (tag_mem[idx][w] == tag)) begin
          rd_hit[p]  = 1'b1;
          rd_data[p] = data_mem[idx][w];
        end
      end
    end
  end

  ////////////////////
  // fill port

  assign fill_idx = fill.line_addr[3 +: SET_BITS];
  assign fill_tag = fill.line_addr[31:3+SET_BITS];

  always_comb begin
    for (int w = 0; w < WAYS; w++) begin
      fill_match[w] = valid_mem[fill_idx][w] && (tag_mem[fill_idx][w] == fill_tag);
    end
  end

  // refill in place when present, else the round-robin victim
  always_comb begin
    fill_way = rr_ptr[fill_idx];
    for (int w = 0; w < WAYS; w++) begin
      if (fill_match[w]) begin
        fill_way = WAY_BITS'(w);
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int s = 0; s < SETS; s++) begin
        valid_mem[s] <= '0;
        rr_ptr[s]    <= '0;
      end
    end else if (fill.valid) begin
      valid_mem[fill_idx][fill_way] <= 1'b1;
      rr_ptr[fill_idx]              <= rr_ptr[fill_idx] + 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (fill.valid) begin
      tag_mem[fill_idx][fill_way]  <= fill_tag;
      data_mem[fill_idx][fill_way] <= fill.data;
    end
  end

  // same line twice in one set
  always_comb begin
    dup_tag = 1'b0;
    for (int s = 0; s < SETS; s++) begin
      for (int i = 0; i < WAYS; i++) begin
        for (int j = i + 1; j < WAYS; j++) begin
          if (valid_mem[s][i] && valid_mem[s][j] && (tag_mem[s][i] == tag_mem[s][j])) begin
            dup_tag = 1'b1;
          end
        end
      end
    end
  end

  a_no_dup_tag: assert property (@(posedge clock) disable iff (reset) !dup_tag)
    else $error("cache_store: two valid ways hold the same tag");

endmodule

`default_nettype wire

// File: logic/fetch_front.sv
`default_nettype none
`timescale 1ns/100ps
`include "icache_defines.svh"

module fetch_front (
  input  wire                                            clock,
  input  wire                                            reset,
  input  wire  fetch_pkg::fetch_addr_t                   fetch_addr,
  output fetch_pkg::fetch_addr_t                         line_addr,
  output logic                                           addr_changed,
  output fetch_pkg::fetch_addr_t [`NUM_PREFETCH-1:0]     prefetch_addrs
);
  import fetch_pkg::*;

  fetch_addr_t last_addr;

  // drop the byte offset
  assign line_addr = {fetch_addr[31:3], 3'b000};

  assign addr_changed = (line_addr != last_addr);

  // an unaligned seed never equals an aligned address,
  // so the first cycle after reset counts as a change
  always_ff @(posedge clock) begin
    if (reset) begin
      last_addr <= '1;
    end else begin
      last_addr <= line_addr;
    end
  end

  ////////////////////
  // prefetch lines

  // next lines in address order
  always_comb begin
    for (int k = 0; k < `NUM_PREFETCH; k++) begin
      prefetch_addrs[k] = line_addr + fetch_addr_t'(8 * (k + 1));
    end
  end

endmodule

`default_nettype wire

// File: logic/fetch_pkg.sv
`default_nettype none
`include "icache_defines.svh"

package fetch_pkg;

  // byte address and one 8-byte line
  typedef logic [31:0] fetch_addr_t;
  typedef logic [63:0] line_data_t;

  // index is addr[5:3], tag is everything above it
  typedef logic [$clog2(`ICACHE_SETS)-1:0]  set_idx_t;
  typedef logic [28-$clog2(`ICACHE_SETS):0] line_tag_t;

  // line returned from memory, written by the cache store
  typedef struct packed {
    logic        valid;
    fetch_addr_t line_addr;
    line_data_t  data;
  } cache_fill_t;

endpackage

`default_nettype wire

// File: logic/icache_defines.svh
`ifndef ICACHE_DEFINES_SVH
`define ICACHE_DEFINES_SVH

////////////////////
// cache geometry

// 32 lines of 8 bytes
`define ICACHE_WAYS 4
`define ICACHE_SETS 8

////////////////////
// miss handling

`define MISS_QUEUE_LEN 8
// lines fetched ahead of the demand line
`define NUM_PREFETCH 2
`define MAX_OUTSTANDING 4

`endif

// File: logic/icache_top.sv
`default_nettype none
`timescale 1ns/100ps
`include "icache_defines.svh"

module icache_top (
  input  wire                               clock,
  input  wire                               reset,
  input  wire  fetch_pkg::fetch_addr_t      fetch_addr,
  input  wire  mem_bus_pkg::mem_tag_t       mem_response,
  input  wire  fetch_pkg::line_data_t       mem_data,
  input  wire  mem_bus_pkg::mem_tag_t       mem_data_tag,
  output fetch_pkg::line_data_t             fetch_data,
  output logic                              fetch_valid,
  output mem_bus_pkg::mem_command_t         mem_command,
  output fetch_pkg::fetch_addr_t            mem_addr
);
  import fetch_pkg::*;
  import mem_bus_pkg::*;

  fetch_addr_t                     line_addr;
  logic                            addr_changed;
  fetch_addr_t [`NUM_PREFETCH-1:0] prefetch_addrs;
  fetch_addr_t [1:0]               rd_addr;
  line_data_t  [1:0]               rd_data;
  logic        [1:0]               rd_hit;
  fetch_addr_t                     check_addr;
  logic                            miss_req;
  logic                            miss_ack;
  miss_request_t                   miss_request;
  cache_fill_t                     fill;

  // port 0 serves fetch, port 1 the miss queue head
  assign rd_addr[0]  = fetch_addr;
  assign rd_addr[1]  = check_addr;
  assign fetch_data  = rd_data[0];
  assign fetch_valid = rd_hit[0];

  ////////////////////
  // blocks

  fetch_front i_fetch_front (
    .clock          (clock),
    .reset          (reset),
    .fetch_addr     (fetch_addr),
    .line_addr      (line_addr),
    .addr_changed   (addr_changed),
    .prefetch_addrs (prefetch_addrs)
  );

  cache_store i_cache_store (
    .clock   (clock),
    .reset   (reset),
    .rd_addr (rd_addr),
    .fill    (fill),
    .rd_data (rd_data),
    .rd_hit  (rd_hit)
  );

  miss_queue i_miss_queue (
    .clock          (clock),
    .reset          (reset),
    .line_addr      (line_addr),
    .addr_changed   (addr_changed),
    .prefetch_addrs (prefetch_addrs),
    .demand_hit     (rd_hit[0]),
    .check_hit      (rd_hit[1]),
    .miss_ack       (miss_ack),
    .check_addr     (check_addr),
    .miss_req       (miss_req),
    .miss_request   (miss_request)
  );

  mem_bus_port i_mem_bus_port (
    .clock        (clock),
    .reset        (reset),
    .miss_req     (miss_req),
    .miss_request (miss_request),
    .mem_response (mem_response),
    .mem_data     (mem_data),
    .mem_data_tag (mem_data_tag),
    .miss_ack     (miss_ack),
    .mem_command  (mem_command),
    .mem_addr     (mem_addr),
    .fill         (fill)
  );

endmodule

`default_nettype wire

// File: logic/mem_bus_pkg.sv
`default_nettype none
`include "icache_defines.svh"

package mem_bus_pkg;

  ////////////////////
  // memory bus

  typedef enum logic [1:0] {
    bus_none = 2'h0,
    bus_load = 2'h1
  } mem_command_t;

  // zero means the command was not accepted
  typedef logic [3:0] mem_tag_t;

  ////////////////////
  // miss queue to bus port

  // line address only, low 3 bits zero
  typedef struct packed {
    fetch_pkg::fetch_addr_t line_addr;
  } miss_request_t;

endpackage

`default_nettype wire

// File: logic/mem_bus_port.sv
`default_nettype none
`timescale 1ns/100ps
`include "icache_defines.svh"

module mem_bus_port (
  input  wire                               clock,
  input  wire                               reset,
  input  wire                               miss_req,
  input  wire  mem_bus_pkg::miss_request_t  miss_request,
  input  wire  mem_bus_pkg::mem_tag_t       mem_response,
  input  wire  fetch_pkg::line_data_t       mem_data,
  input  wire  mem_bus_pkg::mem_tag_t       mem_data_tag,
  output logic                              miss_ack,
  output mem_bus_pkg::mem_command_t         mem_command,
  output fetch_pkg::fetch_addr_t            mem_addr,
  output fetch_pkg::cache_fill_t            fill
);
  import fetch_pkg::*;
  import mem_bus_pkg::*;

  localparam int DEPTH    = `MAX_OUTSTANDING;
  localparam int PTR_BITS = $clog2(DEPTH);

  typedef enum logic [1:0] {
    idle,
    issue,
    acked
  } port_state_t;

  // one load waiting for its data
  typedef struct packed {
    mem_tag_t    tag;
    fetch_addr_t line_addr;
  } pending_t;

  port_state_t         state;
  port_state_t         state_next;
  pending_t            pend_mem [DEPTH];
  logic [PTR_BITS-1:0] wr_ptr;
  logic [PTR_BITS-1:0] rd_ptr;
  logic [PTR_BITS:0]   count;
  logic                accepted;
  logic                tag_match;
  logic                fill_valid;
  fetch_addr_t         fill_addr;
  line_data_t          fill_data;

  ////////////////////
  // request FSM

  // no new attempt while the tag FIFO is full
  always_comb begin
    state_next = state;
    case (state)
      idle: begin
        if (miss_req && (count < DEPTH)) begin
          state_next = issue;
        end
      end
      issue: begin
        if (accepted) begin
          state_next = acked;
        end
      end
      acked: begin
        if (!miss_req) begin
          state_next = idle;
        end
      end
      default: state_next = idle;
    endcase
  end

  // command held until memory returns a tag
  assign accepted    = (state == issue) && (mem_response != '0);
  assign miss_ack    = (state == acked);
  assign mem_command = (state == issue) ? bus_load : bus_none;
  assign mem_addr    = (state == issue) ? miss_request.line_addr : '0;

  ////////////////////
  // outstanding tags

  assign tag_match = (count != '0) && (mem_data_tag != '0) &&
                     (mem_data_tag == pend_mem[rd_ptr].tag);

  always_ff @(posedge clock) begin
    if (reset) begin
      state      <= idle;
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      fill_valid <= 1'b0;
    end else begin
      state      <= state_next;
      fill_valid <= tag_match;
      if (accepted) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (tag_match) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({accepted, tag_match})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (accepted) begin
      pend_mem[wr_ptr] <= '{tag: mem_response, line_addr: miss_request.line_addr};
    end
    if (tag_match) begin
      fill_addr <= pend_mem[rd_ptr].line_addr;
      fill_data <= mem_data;
    end
  end

  // one-cycle fill pulse to the cache store
  assign fill = '{valid: fill_valid, line_addr: fill_addr, data: fill_data};

  // memory answers in the order it accepted
  a_tag_in_order: assert property (@(posedge clock) disable iff (reset)
    ((mem_data_tag != '0) && (count != '0)) |-> (mem_data_tag == pend_mem[rd_ptr].tag))
    else $error("mem_bus_port: returned tag is not the oldest outstanding");

endmodule

`default_nettype wire

// File: logic/miss_queue.sv
`default_nettype none
`timescale 1ns/100ps
`include "icache_defines.svh"

module miss_queue (
  input  wire                                              clock,
  input  wire                                              reset,
  input  wire  fetch_pkg::fetch_addr_t                     line_addr,
  input  wire                                              addr_changed,
  input  wire  fetch_pkg::fetch_addr_t [`NUM_PREFETCH-1:0] prefetch_addrs,
  input  wire                                              demand_hit,
  input  wire                                              check_hit,
  input  wire                                              miss_ack,
  output fetch_pkg::fetch_addr_t                           check_addr,
  output logic                                             miss_req,
  output mem_bus_pkg::miss_request_t                       miss_request
);
  import fetch_pkg::*;

  localparam int LEN      = `MISS_QUEUE_LEN;
  localparam int NUM_CAND = `NUM_PREFETCH + 1;

  logic [LEN-1:0]      q_valid;
  fetch_addr_t         q_addr [LEN];
  logic [LEN-1:0]      next_valid;
  fetch_addr_t         next_addr [LEN];

  fetch_addr_t         cand_addr [NUM_CAND];
  logic [NUM_CAND-1:0] cand_en;
  logic [NUM_CAND-1:0] cand_seen;

  logic                head_idle;
  logic                head_drop;
  logic                req_start;
  logic                handoff;
  logic                pop;

  ////////////////////
  // candidates and CAM

  // demand line first, then the prefetch lines
  always_comb begin
    cand_addr[0] = line_addr;
    cand_en[0]   = addr_changed && !demand_hit;
    for (int k = 0; k < `NUM_PREFETCH; k++) begin
      cand_addr[k+1] = prefetch_addrs[k];
      cand_en[k+1]   = addr_changed;
    end
  end

  always_comb begin
    for (int c = 0; c < NUM_CAND; c++) begin
      cand_seen[c] = 1'b0;
      for (int i = 0; i < LEN; i++) begin
        if (q_valid[i] && (q_addr[i] == cand_addr[c])) begin
          cand_seen[c] = 1'b1;
        end
      end
    end
  end

  ////////////////////
  // head entry

  // head is rechecked on cache port 1 before it goes out
  assign check_addr   = q_addr[0];
  assign head_idle    = q_valid[0] && !miss_req && !miss_ack;
  assign head_drop    = head_idle && check_hit;
  assign req_start    = head_idle && !check_hit;
  assign handoff      = miss_req && miss_ack;
  assign pop          = head_drop || handoff;
  assign miss_request = '{line_addr: q_addr[0]};

  // shift on pop, then append behind the last valid entry
  always_comb begin
    int slot;
    next_valid = q_valid;
    next_addr  = q_addr;
    if (pop) begin
      next_valid = q_valid >> 1;
      for (int i = 0; i < LEN - 1; i++) begin
        next_addr[i] = q_addr[i+1];
      end
    end
    slot = $countones(next_valid);
    for (int c = 0; c < NUM_CAND; c++) begin
      // full queue drops the candidate
      if (cand_en[c] && !cand_seen[c] && (slot < LEN)) begin
        next_valid[slot] = 1'b1;
        next_addr[slot]  = cand_addr[c];
        slot             = slot + 1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      q_valid  <= '0;
      miss_req <= 1'b0;
    end else begin
      q_valid <= next_valid;
      if (req_start) begin
        miss_req <= 1'b1;
      end else if (handoff) begin
        miss_req <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    q_addr <= next_addr;
  end

  a_request_stable: assert property (@(posedge clock) disable iff (reset)
    miss_req |=> (!miss_req || $stable(miss_request)))
    else $error("miss_queue: request changed during handshake");

  a_no_overflow: assert property (@(posedge clock) disable iff (reset)
    (&q_valid && !pop) |=> (&q_valid && $stable(q_addr[LEN-1])))
    else $error("miss_queue: append past the last entry");

endmodule

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
# build and run the icache testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module icache_tb -f all.f -o icache_sim

./obj_dir/icache_sim | tee sim.log

if grep -q "TESTS PASSED" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

// File: verif/icache_tb.sv
`default_nettype none
`timescale 1ns/100ps

module icache_tb;
  import fetch_pkg::*;
  import mem_bus_pkg::*;

  localparam int FETCH_WAIT = 200;
  // about 50 fetches of up to 60 cycles, idle gaps and a 20 cycle stall
  localparam int CYCLE_LIMIT = 4000;
  localparam fetch_addr_t BASE_A = 32'h0000_1000;
  localparam fetch_addr_t BASE_B = 32'h0000_246c;
  localparam fetch_addr_t WINDOW = 32'h0000_3000;

  logic         clock;
  logic         reset;
  logic         hold_off;
  fetch_addr_t  fetch_addr;
  line_data_t   fetch_data;
  logic         fetch_valid;
  mem_command_t mem_command;
  fetch_addr_t  mem_addr;
  mem_tag_t     mem_response;
  line_data_t   mem_data;
  mem_tag_t     mem_data_tag;
  int           errors = 0;
  int           cycles = 0;
  logic [31:0]  rand_state = 32'hb7c6_b0bc;

  icache_top i_dut (
    .clock        (clock),
    .reset        (reset),
    .fetch_addr   (fetch_addr),
    .mem_response (mem_response),
    .mem_data     (mem_data),
    .mem_data_tag (mem_data_tag),
    .fetch_data   (fetch_data),
    .fetch_valid  (fetch_valid),
    .mem_command  (mem_command),
    .mem_addr     (mem_addr)
  );

  tb_memory i_memory (
    .clock        (clock),
    .reset        (reset),
    .hold_off     (hold_off),
    .mem_command  (mem_command),
    .mem_addr     (mem_addr),
    .mem_response (mem_response),
    .mem_data     (mem_data),
    .mem_data_tag (mem_data_tag)
  );

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  always @(posedge clock) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: run stopped after %0d cycles", cycles);
      $display("TESTS FAILED");
      $finish;
    end
  end

  ////////////////////
  // helpers

  // address replicated into both halves, then scrambled
  function automatic line_data_t expected_line(input fetch_addr_t addr);
    fetch_addr_t line;
    line = {addr[31:3], 3'b000};
    return {line, line} ^ 64'h5a5a_0000_c3c3_0000;
  endfunction

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  function automatic int requests_for(input fetch_addr_t addr);
    return i_memory.req_count[addr[13:3]];
  endfunction

  task automatic drive_addr(input fetch_addr_t addr);
    @(posedge clock);
    #1 fetch_addr = addr;
  endtask

  task automatic wait_and_check(input string name, input fetch_addr_t addr);
    int waited;
    waited = 0;
    @(negedge clock);
    while (!fetch_valid && (waited < FETCH_WAIT)) begin
      @(negedge clock);
      waited++;
    end
    if (!fetch_valid) begin
      errors++;
      $display("%s: fetch of %h never became valid", name, addr);
    end else if (fetch_data !== expected_line(addr)) begin
      errors++;
      $display("mismatch %s expected %h actual %h", name, expected_line(addr), fetch_data);
    end
  endtask

  task automatic fetch_and_check(input string name, input fetch_addr_t addr);
    drive_addr(addr);
    wait_and_check(name, addr);
  endtask

  // line must already be present, valid in the same cycle
  task automatic check_hit_now(input string name, input fetch_addr_t addr);
    drive_addr(addr);
    @(negedge clock);
    if (fetch_valid !== 1'b1) begin
      errors++;
      $display("mismatch %s fetch_valid expected 1 actual %b", name, fetch_valid);
    end else if (fetch_data !== expected_line(addr)) begin
      errors++;
      $display("mismatch %s expected %h actual %h", name, expected_line(addr), fetch_data);
    end
  endtask

  // all lines invalid and no bus traffic while in reset
  task automatic check_reset_outputs();
    @(negedge clock);
    if (fetch_valid !== 1'b0) begin
      errors++;
      $display("mismatch reset fetch_valid expected 0 actual %b", fetch_valid);
    end
    if (mem_command !== bus_none) begin
      errors++;
      $display("mismatch reset mem_command expected %h actual %h", bus_none, mem_command);
    end
  endtask

  ////////////////////
  // directed tests

  task automatic test_cold_miss();
    fetch_and_check("cold_miss", BASE_A);
    repeat (40) @(posedge clock);
    drive_addr(BASE_A + 32'h420);
    check_hit_now("cold_miss_return", BASE_A);
  endtask

  task automatic test_prefetch();
    repeat (40) @(posedge clock);
    check_hit_now("prefetch", BASE_A + 32'h8);
    check_hit_now("prefetch", BASE_A + 32'h10);
    repeat (20) @(posedge clock);
    for (int k = 1; k <= 2; k++) begin
      if (requests_for(BASE_A + 8 * k) != 1) begin
        errors++;
        $display("mismatch prefetch_requests expected 1 actual %0d",
                 requests_for(BASE_A + 8 * k));
      end
    end
  endtask

  // five lines of one set push the first one out
  task automatic test_replacement();
    for (int k = 0; k < 5; k++) begin
      fetch_and_check("replacement", BASE_A + 64 * k);
    end
    fetch_and_check("replacement_refetch", BASE_A);
    if (requests_for(BASE_A) < 2) begin
      errors++;
      $display("mismatch replacement_requests expected at least 2 actual %0d",
               requests_for(BASE_A));
    end
  endtask

  task automatic test_back_pressure();
    fetch_addr_t held;
    int          waited;
    repeat (40) @(posedge clock);
    @(posedge clock);
    #1 hold_off = 1'b1;
    drive_addr(BASE_B);
    waited = 0;
    @(negedge clock);
    while ((mem_command != bus_load) && (waited < FETCH_WAIT)) begin
      @(negedge clock);
      waited++;
    end
    if (mem_command != bus_load) begin
      errors++;
      $display("back_pressure: no load command was issued");
    end
    held = mem_addr;
    if (held !== {BASE_B[31:3], 3'b000}) begin
      errors++;
      $display("mismatch back_pressure expected %h actual %h", {BASE_B[31:3], 3'b000}, held);
    end
    repeat (20) begin
      @(negedge clock);
      if ((mem_command != bus_load) || (mem_addr !== held)) begin
        errors++;
        $display("mismatch back_pressure expected %h actual %h", held, mem_addr);
      end
    end
    @(posedge clock);
    #1 hold_off = 1'b0;
    wait_and_check("back_pressure", BASE_B);
  endtask

  task automatic test_random();
    fetch_addr_t addr;
    repeat (40) begin
      rand_state = xorshift(rand_state);
      addr = WINDOW + (rand_state & 32'h3ff);
      fetch_and_check("random", addr);
    end
  endtask

  initial begin
    reset      = 1'b1;
    hold_off   = 1'b0;
    fetch_addr = '0;
    repeat (7) @(posedge clock);
    check_reset_outputs();
    @(posedge clock);
    #1 reset = 1'b0;
    test_cold_miss();
    test_prefetch();
    test_replacement();
    test_back_pressure();
    test_random();
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verif/tb_memory.sv
`default_nettype none
`timescale 1ns/100ps

module tb_memory (
  input  wire                              clock,
  input  wire                              reset,
  input  wire                              hold_off,
  input  wire  mem_bus_pkg::mem_command_t  mem_command,
  input  wire  fetch_pkg::fetch_addr_t     mem_addr,
  output mem_bus_pkg::mem_tag_t            mem_response,
  output fetch_pkg::line_data_t            mem_data,
  output mem_bus_pkg::mem_tag_t            mem_data_tag
);
  import fetch_pkg::*;
  import mem_bus_pkg::*;

  localparam int LATENCY   = 6;
  // request log covers a 16 KB window, one counter per line
  localparam int LOG_LINES = 2048;

  // one accepted load on its way back
  typedef struct packed {
    logic        valid;
    mem_tag_t    tag;
    fetch_addr_t line_addr;
  } load_slot_t;

  load_slot_t pipe [LATENCY];
  mem_tag_t   next_tag;
  logic       accept;
  int         req_count [LOG_LINES];

  // at most one load per cycle, none while held off
  assign accept       = (mem_command == bus_load) && !hold_off;
  assign mem_response = accept ? next_tag : '0;

  always_ff @(posedge clock) begin
    if (reset) begin
      next_tag <= 4'd1;
      for (int i = 0; i < LATENCY; i++) begin
        pipe[i] <= '0;
      end
    end else begin
      pipe[0] <= '{valid: accept, tag: next_tag, line_addr: mem_addr};
      for (int i = 1; i < LATENCY; i++) begin
        pipe[i] <= pipe[i-1];
      end
      if (accept) begin
        next_tag <= (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < LOG_LINES; i++) begin
        req_count[i] <= 0;
      end
    end else if (accept) begin
      req_count[mem_addr[13:3]] <= req_count[mem_addr[13:3]] + 1;
    end
  end

  ////////////////////
  // in-order responses

  always_comb begin
    mem_data_tag = '0;
    mem_data     = '0;
    if (pipe[LATENCY-1].valid) begin
      mem_data_tag = pipe[LATENCY-1].tag;
      mem_data     = {2{pipe[LATENCY-1].line_addr}} ^ 64'h5a5a_0000_c3c3_0000;
    end
  end

endmodule

`default_nettype wire
